// ==== cmd_pkg.sv ====
`default_nettype none

package cmd_pkg;

  // Frame opcodes, first byte of every command
  typedef enum logic [7:0] {
    CMD_WRITE = 8'h01,
    CMD_READ  = 8'h02
  } cmd_op_e;

  localparam logic [7:0] REPLY_ACK = 8'hA5;  // Write frame done
  localparam logic [7:0] REPLY_BAD = 8'hEE;  // Unknown opcode or broken header

  // Decoded command header
  typedef struct packed {
    cmd_op_e    op;
    logic [8:0] addr;   // Word address, byte address bits 10:2
    logic [7:0] count;  // Words left, 0 stands for 256
  } cmd_hdr_t;

  // One beat of a byte stream
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } stream_byte_t;

endpackage

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  localparam int SRAM_BYTES = 2048;
  localparam int WORD_BYTES = 4;
  localparam int MEM_WORDS  = SRAM_BYTES / WORD_BYTES;
  localparam int ADDR_W     = $clog2(MEM_WORDS);
  localparam int DATA_W     = 8 * WORD_BYTES;

  // Single-port request, at most one enable high per cycle
  typedef struct packed {
    logic              wr_en;
    logic              rd_en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  // Read response, one cycle after rd_en
  typedef struct packed {
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== byte_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_packer (
  input  wire                        clock,
  input  wire                        arst_n_i,
  input  wire cmd_pkg::stream_byte_t beat_i,
  input  wire                        beat_stb_i,
  output logic                       word_valid_o,
  output logic [mem_pkg::DATA_W-1:0] word_o
);

  logic [1:0]                 lane_q;
  logic                       valid_q;
  logic [mem_pkg::DATA_W-1:0] word_q;

  // Lane counter and word strobe
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lane_q  <= 2'd0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= beat_stb_i && (lane_q == 2'd3);
      if (beat_stb_i) begin
        // A short frame restarts at lane 0
        lane_q <= beat_i.last ? 2'd0 : lane_q + 2'd1;
      end
    end
  end

  // New bytes enter at the top, so the first byte ends up in bits 7:0
  always_ff @(posedge clock) begin
    if (beat_stb_i) begin
      word_q <= {beat_i.data, word_q[mem_pkg::DATA_W-1:8]};
    end
  end

  assign word_valid_o = valid_q;
  assign word_o       = word_q;

endmodule

`default_nettype wire

// ==== word_unpacker.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_unpacker (
  input  wire                        clock,
  input  wire                        arst_n_i,
  input  wire mem_pkg::mem_rsp_t     rsp_i,
  input  wire                        issue_i,
  input  wire                        last_word_i,
  input  wire cmd_pkg::stream_byte_t reply_i,
  input  wire                        reply_stb_i,
  output logic                       space_o,
  output logic                       reply_done_o,
  output logic                       m_tvalid_o,
  input  wire                        m_tready_i,
  output logic [7:0]                 m_tdata_o,
  output logic                       m_tlast_o
);

  typedef struct packed {
    logic                       last;  // Final word of the read
    logic [mem_pkg::DATA_W-1:0] word;
  } slot_t;

  slot_t                 fifo_q [2];
  slot_t                 head;
  logic                  wr_ptr_q, rd_ptr_q;
  logic [1:0]            fill_q;       // Words held
  logic [1:0]            occ_q;        // Words held plus reads in flight
  logic [1:0]            lane_q;
  logic                  tag_q;        // Last flag of the read in flight
  cmd_pkg::stream_byte_t code_q;
  logic                  code_vld_q;
  logic                  fire, pop, push;

  assign head  = fifo_q[rd_ptr_q];
  assign push  = rsp_i.rvalid;
  assign fire  = m_tvalid_o && m_tready_i;
  assign pop   = fire && !code_vld_q && (lane_q == 2'd3);

  assign space_o = (occ_q < 2'd2);

  // Reply code takes priority, it only shows up with the buffer empty
  always_comb begin
    m_tvalid_o = code_vld_q || (fill_q != 2'd0);
    if (code_vld_q) begin
      m_tdata_o = code_q.data;
      m_tlast_o = code_q.last;
    end else begin
      m_tdata_o = head.word[lane_q*8 +: 8];  // Low byte first
      m_tlast_o = head.last && (lane_q == 2'd3);
    end
  end

  assign reply_done_o = fire && m_tlast_o;

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q   <= 1'b0;
      rd_ptr_q   <= 1'b0;
      fill_q     <= 2'd0;
      occ_q      <= 2'd0;
      lane_q     <= 2'd0;
      tag_q      <= 1'b0;
      code_vld_q <= 1'b0;
    end else begin
      if (issue_i) tag_q <= last_word_i;
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop)  rd_ptr_q <= ~rd_ptr_q;

      if (push && !pop) fill_q <= fill_q + 2'd1;
      else if (pop && !push) fill_q <= fill_q - 2'd1;

      // A slot is reserved at issue and freed after its fourth byte
      if (issue_i && !pop) occ_q <= occ_q + 2'd1;
      else if (pop && !issue_i) occ_q <= occ_q - 2'd1;

      if (fire && !code_vld_q) lane_q <= lane_q + 2'd1;

      if (reply_stb_i) code_vld_q <= 1'b1;
      else if (fire && code_vld_q) code_vld_q <= 1'b0;
    end
  end

  // Payload registers
  always_ff @(posedge clock) begin
    if (push) begin
      fifo_q[wr_ptr_q].word <= rsp_i.rdata;
      fifo_q[wr_ptr_q].last <= tag_q;
    end
    if (reply_stb_i) code_q <= reply_i;
  end

endmodule

`default_nettype wire

// ==== sram_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
  input  wire                    clock,
  input  wire mem_pkg::mem_req_t req_i,
  output mem_pkg::mem_rsp_t      rsp_o,
  input  wire                    arst_n_i
);

  logic [mem_pkg::DATA_W-1:0] mem_q [mem_pkg::MEM_WORDS];
  logic [mem_pkg::DATA_W-1:0] rdata_q;
  logic                       rvalid_q;

  // Synchronous write, registered read
  always_ff @(posedge clock) begin
    if (req_i.wr_en) mem_q[req_i.addr] <= req_i.wdata;
    if (req_i.rd_en) rdata_q <= mem_q[req_i.addr];
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.rd_en;  // Response one cycle after the request
    end
  end

  always_comb begin
    rsp_o.rvalid = rvalid_q;
    rsp_o.rdata  = rdata_q;
  end

endmodule

`default_nettype wire

// ==== cmd_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_parser (
  input  wire                        clock,
  input  wire                        arst_n_i,
  input  wire                        s_tvalid_i,
  output logic                       s_tready_o,
  input  wire  [7:0]                 s_tdata_i,
  input  wire                        s_tlast_i,
  output cmd_pkg::stream_byte_t      beat_o,
  output logic                       beat_stb_o,
  input  wire                        word_valid_i,
  input  wire  [mem_pkg::DATA_W-1:0] word_i,
  output mem_pkg::mem_req_t          mem_req_o,
  output logic                       issue_o,
  output logic                       last_word_o,
  input  wire                        space_i,
  output cmd_pkg::stream_byte_t      reply_o,
  output logic                       reply_stb_o,
  input  wire                        reply_done_i
);

  typedef enum logic [3:0] {
    ST_OPCODE,
    ST_ADDR_LO,
    ST_ADDR_HI,
    ST_COUNT,
    ST_WR_DATA,
    ST_RD_ISSUE,
    ST_DRAIN,
    ST_REPLY,
    ST_WAIT_DONE
  } state_e;

  state_e            state_q, state_d;
  cmd_pkg::cmd_hdr_t hdr_q;
  logic              rdy_q;
  logic              bad_q;       // Reply with REPLY_BAD instead of REPLY_ACK
  logic              xfer, op_known, early_last, advance;

  assign s_tready_o = rdy_q;
  assign xfer       = s_tvalid_i & rdy_q;
  assign op_known   = (s_tdata_i == cmd_pkg::CMD_WRITE) || (s_tdata_i == cmd_pkg::CMD_READ);

  // Frame ended inside the header, only legal on the count byte of a read
  assign early_last = xfer && s_tlast_i &&
                      (state_q == ST_ADDR_LO || state_q == ST_ADDR_HI ||
                       (state_q == ST_COUNT && hdr_q.op != cmd_pkg::CMD_READ));

  assign issue_o     = (state_q == ST_RD_ISSUE) && space_i;
  assign last_word_o = (hdr_q.count == 8'd1);
  assign advance     = word_valid_i | issue_o;  // One word written or read

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_OPCODE: begin
        if (xfer) begin
          if (s_tlast_i) state_d = ST_REPLY;
          else if (op_known) state_d = ST_ADDR_LO;
          else state_d = ST_DRAIN;
        end
      end
      ST_ADDR_LO:   if (xfer) state_d = early_last ? ST_REPLY : ST_ADDR_HI;
      ST_ADDR_HI:   if (xfer) state_d = early_last ? ST_REPLY : ST_COUNT;
      ST_COUNT: begin
        if (early_last) state_d = ST_REPLY;
        else if (xfer) state_d = (hdr_q.op == cmd_pkg::CMD_READ) ? ST_RD_ISSUE : ST_WR_DATA;
      end
      ST_WR_DATA:   if (xfer && s_tlast_i) state_d = ST_REPLY;  // Final word lands next cycle
      ST_RD_ISSUE:  if (issue_o && last_word_o) state_d = ST_WAIT_DONE;
      ST_DRAIN:     if (xfer && s_tlast_i) state_d = ST_REPLY;
      ST_REPLY:     state_d = ST_WAIT_DONE;
      ST_WAIT_DONE: if (reply_done_i) state_d = ST_OPCODE;
      default:      state_d = ST_OPCODE;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_OPCODE;
      rdy_q   <= 1'b0;
      bad_q   <= 1'b0;
      hdr_q   <= '0;
    end else begin
      state_q <= state_d;
      // Registered so ready stays low through reset
      rdy_q   <= (state_d == ST_OPCODE) || (state_d == ST_ADDR_LO) ||
                 (state_d == ST_ADDR_HI) || (state_d == ST_COUNT) ||
                 (state_d == ST_WR_DATA) || (state_d == ST_DRAIN);

      if (xfer && state_q == ST_OPCODE) begin
        hdr_q.op <= cmd_pkg::cmd_op_e'(s_tdata_i);
        bad_q    <= !op_known || s_tlast_i;
      end else if (early_last) begin
        bad_q <= 1'b1;
      end

      if (xfer && state_q == ST_ADDR_LO) hdr_q.addr[5:0] <= s_tdata_i[7:2];
      if (xfer && state_q == ST_ADDR_HI) hdr_q.addr[8:6] <= s_tdata_i[2:0];
      if (xfer && state_q == ST_COUNT)   hdr_q.count     <= s_tdata_i;

      if (advance) begin
        hdr_q.addr  <= hdr_q.addr + 9'd1;   // Wraps after 511
        hdr_q.count <= hdr_q.count - 8'd1;
      end
    end
  end

  // Data bytes go on to the packer
  always_comb begin
    beat_o.data = s_tdata_i;
    beat_o.last = s_tlast_i;
    beat_stb_o  = xfer && (state_q == ST_WR_DATA);
  end

  always_comb begin
    mem_req_o.wr_en = word_valid_i;
    mem_req_o.rd_en = issue_o;
    mem_req_o.addr  = hdr_q.addr;
    mem_req_o.wdata = word_i;
  end

  always_comb begin
    reply_o.data = bad_q ? cmd_pkg::REPLY_BAD : cmd_pkg::REPLY_ACK;
    reply_o.last = 1'b1;  // Reply codes are single-byte frames
    reply_stb_o  = (state_q == ST_REPLY);
  end

endmodule

`default_nettype wire

// ==== stream_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_mem_top (
  input  wire        clock,
  input  wire        arst_n_i,

  // Command stream, bulk OUT side
  input  wire        s_tvalid_i,
  output logic       s_tready_o,
  input  wire  [7:0] s_tdata_i,
  input  wire        s_tlast_i,

  // Reply stream, bulk IN side
  output logic       m_tvalid_o,
  input  wire        m_tready_i,
  output logic [7:0] m_tdata_o,
  output logic       m_tlast_o
);

  cmd_pkg::stream_byte_t       beat_w, reply_w;
  logic                        beat_stb_w, reply_stb_w, reply_done_w;
  logic                        word_valid_w, issue_w, last_word_w, space_w;
  logic [mem_pkg::DATA_W-1:0]  word_w;
  mem_pkg::mem_req_t           mem_req_w;
  mem_pkg::mem_rsp_t           mem_rsp_w;

  cmd_parser u_parser (
    .clock       (clock),
    .arst_n_i    (arst_n_i),
    .s_tvalid_i  (s_tvalid_i),
    .s_tready_o  (s_tready_o),
    .s_tdata_i   (s_tdata_i),
    .s_tlast_i   (s_tlast_i),
    .beat_o      (beat_w),
    .beat_stb_o  (beat_stb_w),
    .word_valid_i(word_valid_w),
    .word_i      (word_w),
    .mem_req_o   (mem_req_w),
    .issue_o     (issue_w),
    .last_word_o (last_word_w),
    .space_i     (space_w),
    .reply_o     (reply_w),
    .reply_stb_o (reply_stb_w),
    .reply_done_i(reply_done_w)
  );

  byte_packer u_packer (
    .clock       (clock),
    .arst_n_i    (arst_n_i),
    .beat_i      (beat_w),
    .beat_stb_i  (beat_stb_w),
    .word_valid_o(word_valid_w),
    .word_o      (word_w)
  );

  sram_bank u_sram (
    .clock   (clock),
    .req_i   (mem_req_w),
    .rsp_o   (mem_rsp_w),
    .arst_n_i(arst_n_i)
  );

  word_unpacker u_unpacker (
    .clock       (clock),
    .arst_n_i    (arst_n_i),
    .rsp_i       (mem_rsp_w),
    .issue_i     (issue_w),
    .last_word_i (last_word_w),
    .reply_i     (reply_w),
    .reply_stb_i (reply_stb_w),
    .space_o     (space_w),
    .reply_done_o(reply_done_w),
    .m_tvalid_o  (m_tvalid_o),
    .m_tready_i  (m_tready_i),
    .m_tdata_o   (m_tdata_o),
    .m_tlast_o   (m_tlast_o)
  );

endmodule

`default_nettype wire

// ==== tb_stream_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_stream_mem;

  logic       clock = 1'b0;
  logic       arst_n_i;
  logic       s_tvalid_i;
  logic       s_tready_o;
  logic [7:0] s_tdata_i;
  logic       s_tlast_i;
  logic       m_tvalid_o;
  logic       m_tready_i = 1'b0;
  logic [7:0] m_tdata_o;
  logic       m_tlast_o;

  logic [8:0]  tx_q [$];      // Frame bytes with last in bit 8
  logic [8:0]  exp_q [$];     // Expected reply bytes in the same layout
  logic [31:0] shadow [512];  // Model of the SRAM contents
  logic [8:0]  got_b, want_b;
  int          errors     = 0;
  int          bytes_sent = 0;
  int          rx_count   = 0;
  int          cycles     = 0;
  int          bp_pct     = 0;  // Chance in percent that m_tready_i is low

  stream_mem_top dut0 (
    .clock     (clock),
    .arst_n_i  (arst_n_i),
    .s_tvalid_i(s_tvalid_i),
    .s_tready_o(s_tready_o),
    .s_tdata_i (s_tdata_i),
    .s_tlast_i (s_tlast_i),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tdata_o (m_tdata_o),
    .m_tlast_o (m_tlast_o)
  );

  always #10 clock = ~clock;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      errors = errors + 1;
      $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, want);
    end
  endtask

  // Expected reply byte idx of a frame with last in bit 8
  function automatic logic [8:0] ref_reply(input logic [7:0] op, input logic [8:0] wa,
                                           input int nwords, input int idx);
    logic [31:0] w;
    logic [8:0]  a;
    if (op == cmd_pkg::CMD_WRITE) return {1'b1, cmd_pkg::REPLY_ACK};
    if (op != cmd_pkg::CMD_READ) return {1'b1, cmd_pkg::REPLY_BAD};
    a = wa + 9'(idx / 4);  // Word address wraps after 511
    w = shadow[a];
    return {idx == 4 * nwords - 1, 8'(w >> (8 * (idx % 4)))};
  endfunction

  task automatic push_expected(input logic [7:0] op, input logic [8:0] wa,
                               input int nwords);
    int n;
    n = (op == cmd_pkg::CMD_READ) ? 4 * nwords : 1;
    for (int i = 0; i < n; i++) exp_q.push_back(ref_reply(op, wa, nwords, i));
  endtask

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic send_byte(input logic [8:0] b);
    logic accepted;
    if (($urandom % 4) == 0) begin
      s_tvalid_i = 1'b0;
      repeat (1 + $urandom % 3) @(negedge clock);
    end
    s_tvalid_i = 1'b1;
    s_tdata_i  = b[7:0];
    s_tlast_i  = b[8];
    accepted   = 1'b0;
    while (!accepted) begin
      accepted = s_tready_o;  // Registered and stable until the next rising edge
      @(negedge clock);
    end
    s_tvalid_i = 1'b0;
    bytes_sent = bytes_sent + 1;
  endtask

  task automatic send_frame();
    for (int i = 0; i < tx_q.size(); i++) send_byte(tx_q[i]);
  endtask

  task automatic write_words(input int byte_addr, input int nwords);
    logic [31:0] w;
    logic [8:0]  wa;
    wa = 9'(byte_addr >> 2);
    tx_q.delete();
    tx_q.push_back({1'b0, cmd_pkg::CMD_WRITE});
    tx_q.push_back({1'b0, 8'(byte_addr)});
    tx_q.push_back({1'b0, 8'(byte_addr >> 8)});
    tx_q.push_back({1'b0, 8'(nwords)});  // 256 goes out as 0
    for (int i = 0; i < nwords; i++) begin
      w = $urandom;
      shadow[wa + 9'(i)] = w;
      for (int b = 0; b < 4; b++) begin
        tx_q.push_back({(i == nwords - 1) && (b == 3), 8'(w >> (8 * b))});
      end
    end
    push_expected(cmd_pkg::CMD_WRITE, wa, nwords);
    send_frame();
  endtask

  task automatic read_words(input int byte_addr, input int nwords);
    tx_q.delete();
    tx_q.push_back({1'b0, cmd_pkg::CMD_READ});
    tx_q.push_back({1'b0, 8'(byte_addr)});
    tx_q.push_back({1'b0, 8'(byte_addr >> 8)});
    tx_q.push_back({1'b1, 8'(nwords)});
    push_expected(cmd_pkg::CMD_READ, 9'(byte_addr >> 2), nwords);
    send_frame();
  endtask

  // Unknown opcode followed by len-1 filler bytes
  task automatic bad_frame(input int len);
    logic [7:0] op;
    op = 8'($urandom);
    while (op == cmd_pkg::CMD_WRITE || op == cmd_pkg::CMD_READ) op = 8'($urandom);
    tx_q.delete();
    tx_q.push_back({len == 1, op});
    for (int i = 1; i < len; i++) tx_q.push_back({i == len - 1, 8'($urandom)});
    push_expected(op, 9'd0, 1);
    send_frame();
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) @(negedge clock);
    repeat (8) @(negedge clock);  // Room for any stray extra byte
  endtask

  always @(negedge clock) begin
    m_tready_i = ($urandom % 100) >= bp_pct;
  end

  // Compare every output transfer with the head of the expected queue
  always @(posedge clock) begin
    if (arst_n_i && m_tvalid_o && m_tready_i) begin
      got_b = {m_tlast_o, m_tdata_o};
      // Input side stays closed while a reply is pending
      check_value("s_tready_o during reply", 32'(s_tready_o), 32'd0);
      if (exp_q.size() == 0) begin
        errors = errors + 1;
        $display("Unexpected reply byte %h at %0t with no reply pending", got_b, $time);
      end else begin
        want_b = exp_q.pop_front();
        check_value($sformatf("reply byte %0d {last,data}", rx_count),
                    32'(got_b), 32'(want_b));
      end
      rx_count = rx_count + 1;
    end
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > 40 * bytes_sent + 2000) begin
      $display("Simulation timed out after %0d cycles, %0d reply bytes still expected",
               cycles, exp_q.size());
      $display("Errors: %0d", errors);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    arst_n_i   = 1'b0;
    s_tvalid_i = 1'b0;
    s_tdata_i  = 8'h00;
    s_tlast_i  = 1'b0;
    void'($urandom(78));
    repeat (16) @(negedge clock);
    check_value("s_tready_o in reset", 32'(s_tready_o), 32'd0);
    check_value("m_tvalid_o in reset", 32'(m_tvalid_o), 32'd0);
    arst_n_i = 1'b1;
    @(negedge clock);
    check_value("s_tready_o after reset", 32'(s_tready_o), 32'd1);

    // Fill the whole SRAM so every read has a known model value
    write_words(0, 256);
    write_words(1024, 256);

    bp_pct = 25;
    write_words(16'h0100, 16);  // Write then read back
    read_words(16'h0100, 16);

    bad_frame(2 + $urandom % 12);
    bad_frame(1);               // Last on the opcode byte
    write_words(16'h0333, 3);   // Low address bits ignored
    read_words(16'h0330, 3);

    bp_pct = 70;                // Heavy back-pressure on long reads
    write_words(16'h0400, 64);
    read_words(16'h0400, 64);
    read_words(16'h0010, 200);

    bp_pct = 25;
    write_words(2044, 8);       // Wraps from word 511 to word 0
    read_words(2040, 10);
    read_words(16'hFFFC, 4);    // High address bits ignored

    read_words(16'h0200, 256);  // Count byte 0
    wait_idle();

    $display("Errors: %0d, bytes sent: %0d, bytes received: %0d",
             errors, bytes_sent, rx_count);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== stream_mem.f ====
cmd_pkg.sv
mem_pkg.sv
byte_packer.sv
word_unpacker.sv
sram_bank.sv
cmd_parser.sv
stream_mem_top.sv
tb_stream_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  --top-module tb_stream_mem \
  -f stream_mem.f \
  -o sim_stream_mem

./obj_dir/sim_stream_mem | tee sim.log

if grep -qx "All tests passed" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
